/* verilog/m92_dl_pkg.sv */
//////////////////////////////
// M92 download path package
// Shared widths, stream indices, queue sizing
// and the SDRAM port owner encoding
//////////////////////////////

package m92_dl_pkg;

    ////////////////////////////// Types

    // Byte address in the download and SDRAM space
    typedef logic [24:0] rom_addr_t;

    // One SDRAM data word
    typedef logic [15:0] sdr_word_t;

    // Byte enables, bit 0 is the even (low) byte
    typedef logic [1:0] byte_en_t;

    typedef logic [7:0] ioctl_index_t;

    // DIP banks are active low
    typedef logic [7:0] dip_bank_t;
    typedef logic [23:0] dip_word_t;

    typedef enum logic [1:0] {
        OWNER_IDLE = 2'd0,
        OWNER_ROM  = 2'd1,
        OWNER_CPU  = 2'd2
    } port_owner_e;

    ////////////////////////////// Constants

    localparam int IOCTL_INDEX_ROM = 0;
    localparam int IOCTL_INDEX_DIP = 254;

    localparam int DIP_BANK_COUNT = 8;
    localparam int DIP_SEL_W = $clog2(DIP_BANK_COUNT);

    // Queue depth doubles as the initial credit count
    localparam int ROM_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(ROM_QUEUE_DEPTH);

    // Holds a 0..depth count, used for credits and queue fill
    localparam int COUNT_W = $clog2(ROM_QUEUE_DEPTH + 1);

    // Download stalls below this many credits
    localparam int CREDIT_RESERVE = 2;

endpackage

/* verilog/ioctl_decoder.sv */
//////////////////////////////
// Host stream decoder
// Routes ROM bytes to the packer and
// captures DIP switch bank writes
//////////////////////////////

module ioctl_decoder (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     ioctl_wr,
    input  m92_dl_pkg::ioctl_index_t ioctl_index,
    input  m92_dl_pkg::rom_addr_t    ioctl_addr,
    input  m92_dl_pkg::dip_bank_t    ioctl_dout,
    input  logic                     stall,
    output logic                     rom_byte_valid,
    output m92_dl_pkg::rom_addr_t    rom_byte_addr,
    output m92_dl_pkg::dip_bank_t    rom_byte_data,
    output m92_dl_pkg::dip_word_t    dip_sw
);

    logic accept;
    logic is_rom;
    logic is_dip;
    logic [m92_dl_pkg::DIP_SEL_W-1:0] bank_sel;

    m92_dl_pkg::dip_bank_t banks [m92_dl_pkg::DIP_BANK_COUNT];

    assign accept = ioctl_wr && !stall;
    assign is_rom = (ioctl_index == m92_dl_pkg::ioctl_index_t'(m92_dl_pkg::IOCTL_INDEX_ROM));
    assign is_dip = (ioctl_index == m92_dl_pkg::ioctl_index_t'(m92_dl_pkg::IOCTL_INDEX_DIP))
                    && (ioctl_addr < m92_dl_pkg::DIP_BANK_COUNT);
    assign bank_sel = ioctl_addr[m92_dl_pkg::DIP_SEL_W-1:0];

    // One-cycle byte register towards the packer
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rom_byte_valid <= 1'b0;
        end else begin
            rom_byte_valid <= accept && is_rom;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept && is_rom) begin
            rom_byte_addr <= ioctl_addr;
            rom_byte_data <= ioctl_dout;
        end
    end

    // Switches read as open (all ones) until the host writes them
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < m92_dl_pkg::DIP_BANK_COUNT; i++) begin
                banks[i] <= '1;
            end
        end else if (accept && is_dip) begin
            banks[bank_sel] <= ioctl_dout;
        end
    end

    // Bank 2 in the top byte
    assign dip_sw = {banks[2], banks[1], banks[0]};

    // A stalled host byte stays on the bus and must not leak through to the packer
    a_no_byte_after_stall: assert property (
        @(posedge clk_sys) disable iff (reset)
        (ioctl_wr && stall) |=> !rom_byte_valid && ioctl_wr
                                && $stable(ioctl_index) && $stable(ioctl_addr)
                                && $stable(ioctl_dout)
    );

endmodule

/* verilog/rom_word_packer.sv */
//////////////////////////////
// ROM word packer
// Pairs download bytes into 16-bit words,
// keeps the queue credits and stalls the host
//////////////////////////////

module rom_word_packer (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  ioctl_download,
    input  logic                  rom_byte_valid,
    input  m92_dl_pkg::rom_addr_t rom_byte_addr,
    input  m92_dl_pkg::dip_bank_t rom_byte_data,
    input  logic                  credit_return,
    output logic                  word_push,
    output m92_dl_pkg::rom_addr_t word_addr,
    output m92_dl_pkg::sdr_word_t word_data,
    output m92_dl_pkg::byte_en_t  word_be,
    output logic                  ioctl_wait
);

    // Pending even byte
    logic                  pend_valid;
    m92_dl_pkg::rom_addr_t pend_addr;
    m92_dl_pkg::dip_bank_t pend_data;

    logic [m92_dl_pkg::COUNT_W-1:0] credits;

    m92_dl_pkg::rom_addr_t even_addr;
    logic                  pair_match;

    logic                  push_now;
    m92_dl_pkg::rom_addr_t push_addr;
    m92_dl_pkg::sdr_word_t push_data;
    m92_dl_pkg::byte_en_t  push_be;

    assign even_addr = {rom_byte_addr[$bits(m92_dl_pkg::rom_addr_t)-1:1], 1'b0};
    assign pair_match = pend_valid && (pend_addr == even_addr);

    ////////////////////////////// Word build

    always_comb begin
        push_now = 1'b0;
        push_addr = pend_addr;
        push_data = {8'h00, pend_data};
        push_be = 2'b01;
        if (rom_byte_valid) begin
            if (rom_byte_addr[0]) begin
                push_now = 1'b1;
                push_addr = even_addr;
                if (pair_match) begin
                    push_data = {rom_byte_data, pend_data};
                    push_be = 2'b11;
                end else begin
                    // Odd byte without its partner goes out alone
                    push_data = {rom_byte_data, 8'h00};
                    push_be = 2'b10;
                end
            end else begin
                // New even byte displaces an orphaned one
                push_now = pend_valid;
            end
        end else if (!ioctl_download && pend_valid) begin
            // Trailing even byte at end of download
            push_now = 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pend_valid <= 1'b0;
            word_push <= 1'b0;
        end else begin
            word_push <= push_now;
            if (rom_byte_valid && !rom_byte_addr[0]) begin
                pend_valid <= 1'b1;
            end else if (rom_byte_valid && pair_match) begin
                pend_valid <= 1'b0;
            end else if (!rom_byte_valid && !ioctl_download) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rom_byte_valid && !rom_byte_addr[0]) begin
            pend_addr <= rom_byte_addr;
            pend_data <= rom_byte_data;
        end
        if (push_now) begin
            word_addr <= push_addr;
            word_data <= push_data;
            word_be <= push_be;
        end
    end

    ////////////////////////////// Credits

    // Spent when the push is decided, so the reserve sees it early
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            credits <= m92_dl_pkg::COUNT_W'(m92_dl_pkg::ROM_QUEUE_DEPTH);
        end else begin
            case ({push_now, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Reserve covers the byte already in the decoder register
    assign ioctl_wait = (credits < m92_dl_pkg::CREDIT_RESERVE);

    a_credit_bounds: assert property (
        @(posedge clk_sys) disable iff (reset)
        (credits <= m92_dl_pkg::ROM_QUEUE_DEPTH) && !(push_now && credits == '0)
    );

endmodule

/* verilog/rom_write_queue.sv */
//////////////////////////////
// ROM write queue
// Circular FIFO of packed words, one credit
// goes back to the packer per retired word
//////////////////////////////

module rom_write_queue (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  word_push,
    input  m92_dl_pkg::rom_addr_t word_addr,
    input  m92_dl_pkg::sdr_word_t word_data,
    input  m92_dl_pkg::byte_en_t  word_be,
    input  logic                  q_pop,
    output logic                  q_valid,
    output m92_dl_pkg::rom_addr_t q_addr,
    output m92_dl_pkg::sdr_word_t q_data,
    output m92_dl_pkg::byte_en_t  q_be,
    output logic                  credit_return
);

    m92_dl_pkg::rom_addr_t addr_mem [m92_dl_pkg::ROM_QUEUE_DEPTH];
    m92_dl_pkg::sdr_word_t data_mem [m92_dl_pkg::ROM_QUEUE_DEPTH];
    m92_dl_pkg::byte_en_t  be_mem   [m92_dl_pkg::ROM_QUEUE_DEPTH];

    logic [m92_dl_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [m92_dl_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [m92_dl_pkg::COUNT_W-1:0]     count;
    logic                               full;

    function automatic logic [m92_dl_pkg::QUEUE_PTR_W-1:0] next_ptr(
        input logic [m92_dl_pkg::QUEUE_PTR_W-1:0] ptr
    );
        if (ptr == m92_dl_pkg::QUEUE_PTR_W'(m92_dl_pkg::ROM_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign q_valid = (count != '0);
    assign full = (count == m92_dl_pkg::COUNT_W'(m92_dl_pkg::ROM_QUEUE_DEPTH));

    always_ff @(posedge clk_sys) begin
        if (word_push) begin
            addr_mem[wr_ptr] <= word_addr;
            data_mem[wr_ptr] <= word_data;
            be_mem[wr_ptr] <= word_be;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (word_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (q_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({word_push, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry
    assign q_addr = addr_mem[rd_ptr];
    assign q_data = data_mem[rd_ptr];
    assign q_be = be_mem[rd_ptr];

    assign credit_return = q_pop;

    a_no_push_full: assert property (
        @(posedge clk_sys) disable iff (reset) word_push |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk_sys) disable iff (reset) q_pop |-> q_valid
    );

endmodule

/* verilog/sdram_ch3_mux.sv */
//////////////////////////////
// SDRAM channel 3 arbiter
// Shares one SDRAM port between queued ROM
// writes and CPU requests
//////////////////////////////

module sdram_ch3_mux (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  ioctl_download,
    input  logic                  q_valid,
    input  m92_dl_pkg::rom_addr_t q_addr,
    input  m92_dl_pkg::sdr_word_t q_data,
    input  m92_dl_pkg::byte_en_t  q_be,
    input  m92_dl_pkg::rom_addr_t cpu_addr,
    input  m92_dl_pkg::sdr_word_t cpu_din,
    input  m92_dl_pkg::byte_en_t  cpu_wr_sel,
    input  logic                  cpu_req,
    input  logic                  sdr_rdy,
    output logic                  q_pop,
    output logic                  cpu_rdy,
    output logic [$bits(m92_dl_pkg::rom_addr_t)-2:0] sdr_addr,
    output m92_dl_pkg::sdr_word_t sdr_din,
    output m92_dl_pkg::byte_en_t  sdr_be,
    output logic                  sdr_rnw,
    output logic                  sdr_req
);

    localparam int AW = $bits(m92_dl_pkg::rom_addr_t);

    m92_dl_pkg::port_owner_e owner;

    // Download end reaches the queue up to three cycles late
    logic [2:0] dl_tail;

    // CPU is locked out for the whole download and until the queue drains
    logic rom_busy;
    assign rom_busy = ioctl_download || (|dl_tail) || q_valid;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dl_tail <= '0;
        end else begin
            dl_tail <= {dl_tail[1:0], ioctl_download};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            owner <= m92_dl_pkg::OWNER_IDLE;
            sdr_req <= 1'b0;
        end else begin
            case (owner)
                m92_dl_pkg::OWNER_IDLE: begin
                    if (q_valid) begin
                        owner <= m92_dl_pkg::OWNER_ROM;
                        sdr_req <= 1'b1;
                    end else if (!rom_busy && cpu_req) begin
                        owner <= m92_dl_pkg::OWNER_CPU;
                        sdr_req <= 1'b1;
                    end
                end
                m92_dl_pkg::OWNER_ROM, m92_dl_pkg::OWNER_CPU: begin
                    if (sdr_rdy) begin
                        owner <= m92_dl_pkg::OWNER_IDLE;
                        sdr_req <= 1'b0;
                    end
                end
                default: begin
                    owner <= m92_dl_pkg::OWNER_IDLE;
                    sdr_req <= 1'b0;
                end
            endcase
        end
    end

    // Request fields latched once per grant
    always_ff @(posedge clk_sys) begin
        if (owner == m92_dl_pkg::OWNER_IDLE) begin
            if (q_valid) begin
                sdr_addr <= q_addr[AW-1:1];
                sdr_din <= q_data;
                sdr_be <= q_be;
                sdr_rnw <= 1'b0;
            end else begin
                sdr_addr <= cpu_addr[AW-1:1];
                sdr_din <= cpu_din;
                sdr_be <= cpu_wr_sel;
                sdr_rnw <= ~(|cpu_wr_sel);
            end
        end
    end

    // Ready is steered back to whoever owns the port
    assign q_pop = (owner == m92_dl_pkg::OWNER_ROM) && sdr_rdy;
    assign cpu_rdy = (owner == m92_dl_pkg::OWNER_CPU) && sdr_rdy;

    a_req_held: assert property (
        @(posedge clk_sys) disable iff (reset)
        (sdr_req && !sdr_rdy) |=> sdr_req && $stable({sdr_addr, sdr_din, sdr_be, sdr_rnw})
    );

endmodule

/* verilog/m92_download_top.sv */
//////////////////////////////
// M92 download path top
// Decoder, packer, write queue and
// SDRAM port arbiter in one chain
//////////////////////////////

module m92_download_top (
    input  logic                     clk_sys,
    input  logic                     reset,

    // Host stream
    input  logic                     ioctl_download,
    input  logic                     ioctl_wr,
    input  m92_dl_pkg::ioctl_index_t ioctl_index,
    input  m92_dl_pkg::rom_addr_t    ioctl_addr,
    input  m92_dl_pkg::dip_bank_t    ioctl_dout,
    output logic                     ioctl_wait,

    // CPU port
    input  m92_dl_pkg::rom_addr_t    cpu_addr,
    input  m92_dl_pkg::sdr_word_t    cpu_din,
    input  m92_dl_pkg::byte_en_t     cpu_wr_sel,
    input  logic                     cpu_req,
    output logic                     cpu_rdy,
    output m92_dl_pkg::sdr_word_t    cpu_dout,

    // SDRAM channel
    output logic [$bits(m92_dl_pkg::rom_addr_t)-2:0] sdr_addr,
    output m92_dl_pkg::sdr_word_t    sdr_din,
    output m92_dl_pkg::byte_en_t     sdr_be,
    output logic                     sdr_rnw,
    output logic                     sdr_req,
    input  logic                     sdr_rdy,
    input  m92_dl_pkg::sdr_word_t    sdr_dout,

    output m92_dl_pkg::dip_word_t    dip_sw
);

    logic                  rom_byte_valid;
    m92_dl_pkg::rom_addr_t rom_byte_addr;
    m92_dl_pkg::dip_bank_t rom_byte_data;

    logic                  word_push;
    m92_dl_pkg::rom_addr_t word_addr;
    m92_dl_pkg::sdr_word_t word_data;
    m92_dl_pkg::byte_en_t  word_be;
    logic                  credit_return;

    logic                  q_valid;
    m92_dl_pkg::rom_addr_t q_addr;
    m92_dl_pkg::sdr_word_t q_data;
    m92_dl_pkg::byte_en_t  q_be;
    logic                  q_pop;

    ioctl_decoder ioctl_decoder_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_wr       (ioctl_wr),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .stall          (ioctl_wait),
        .rom_byte_valid (rom_byte_valid),
        .rom_byte_addr  (rom_byte_addr),
        .rom_byte_data  (rom_byte_data),
        .dip_sw         (dip_sw)
    );

    rom_word_packer rom_word_packer_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .rom_byte_valid (rom_byte_valid),
        .rom_byte_addr  (rom_byte_addr),
        .rom_byte_data  (rom_byte_data),
        .credit_return  (credit_return),
        .word_push      (word_push),
        .word_addr      (word_addr),
        .word_data      (word_data),
        .word_be        (word_be),
        .ioctl_wait     (ioctl_wait)
    );

    rom_write_queue rom_write_queue_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .word_push     (word_push),
        .word_addr     (word_addr),
        .word_data     (word_data),
        .word_be       (word_be),
        .q_pop         (q_pop),
        .q_valid       (q_valid),
        .q_addr        (q_addr),
        .q_data        (q_data),
        .q_be          (q_be),
        .credit_return (credit_return)
    );

    sdram_ch3_mux sdram_ch3_mux_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .q_valid        (q_valid),
        .q_addr         (q_addr),
        .q_data         (q_data),
        .q_be           (q_be),
        .cpu_addr       (cpu_addr),
        .cpu_din        (cpu_din),
        .cpu_wr_sel     (cpu_wr_sel),
        .cpu_req        (cpu_req),
        .sdr_rdy        (sdr_rdy),
        .q_pop          (q_pop),
        .cpu_rdy        (cpu_rdy),
        .sdr_addr       (sdr_addr),
        .sdr_din        (sdr_din),
        .sdr_be         (sdr_be),
        .sdr_rnw        (sdr_rnw),
        .sdr_req        (sdr_req)
    );

    // Read data comes straight from the SDRAM channel
    assign cpu_dout = sdr_dout;

endmodule

/* verification/tb_m92_download.sv */
//////////////////////////////
// M92 download path testbench
// Replays host download and CPU records from
// the data file against an SDRAM model with
// random latency, and checks the written image
//////////////////////////////

module tb_m92_download;

    localparam int MAX_WORDS = 256;
    localparam int CYCLES_PER_RECORD = 64;

    logic clk_sys = 1'b0;
    logic reset;

    logic                     ioctl_download;
    logic                     ioctl_wr;
    m92_dl_pkg::ioctl_index_t ioctl_index;
    m92_dl_pkg::rom_addr_t    ioctl_addr;
    m92_dl_pkg::dip_bank_t    ioctl_dout;
    logic                     ioctl_wait;

    m92_dl_pkg::rom_addr_t cpu_addr;
    m92_dl_pkg::sdr_word_t cpu_din;
    m92_dl_pkg::byte_en_t  cpu_wr_sel;
    logic                  cpu_req;
    logic                  cpu_rdy;
    m92_dl_pkg::sdr_word_t cpu_dout;

    logic [23:0]           sdr_addr;
    m92_dl_pkg::sdr_word_t sdr_din;
    m92_dl_pkg::byte_en_t  sdr_be;
    logic                  sdr_rnw;
    logic                  sdr_req;
    logic                  sdr_rdy = 1'b0;
    m92_dl_pkg::sdr_word_t sdr_dout = '0;

    m92_dl_pkg::dip_word_t dip_sw;

    // Four words per record: kind, index, address, data
    logic [31:0] records [MAX_WORDS];
    int          num_records = 0;

    // Word-addressed SDRAM contents and the expected image
    logic [15:0] sdr_mem [int];
    logic [15:0] exp_mem [int];

    integer seed = 32'hc746;
    int     delay;
    logic   busy;
    logic   wait_seen = 1'b0;
    logic   cpu_busy = 1'b0;
    logic   cpu_in_dl = 1'b0;

    m92_download_top m92_download_top_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_wait     (ioctl_wait),
        .cpu_addr       (cpu_addr),
        .cpu_din        (cpu_din),
        .cpu_wr_sel     (cpu_wr_sel),
        .cpu_req        (cpu_req),
        .cpu_rdy        (cpu_rdy),
        .cpu_dout       (cpu_dout),
        .sdr_addr       (sdr_addr),
        .sdr_din        (sdr_din),
        .sdr_be         (sdr_be),
        .sdr_rnw        (sdr_rnw),
        .sdr_req        (sdr_req),
        .sdr_rdy        (sdr_rdy),
        .sdr_dout       (sdr_dout),
        .dip_sw         (dip_sw)
    );

    always #20 clk_sys = ~clk_sys;

    ////////////////////////////// Helpers

    // Unwritten words read back as a pattern of their full address
    function automatic logic [15:0] fill_word(input int waddr);
        logic [23:0] a;
        a = waddr[23:0];
        return a[15:0] ^ {a[7:0], a[23:16]};
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old_word,
                                                input logic [15:0] new_word,
                                                input logic [1:0] be);
        logic [15:0] result;
        result[7:0] = be[0] ? new_word[7:0] : old_word[7:0];
        result[15:8] = be[1] ? new_word[15:8] : old_word[15:8];
        return result;
    endfunction

    function automatic logic [15:0] model_word(input int waddr);
        return sdr_mem.exists(waddr) ? sdr_mem[waddr] : fill_word(waddr);
    endfunction

    function automatic logic [15:0] expected_word(input int waddr);
        return exp_mem.exists(waddr) ? exp_mem[waddr] : fill_word(waddr);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic check_image(input string name);
        foreach (exp_mem[k]) begin
            check_value($sformatf("%s word %h", name, k), 32'(exp_mem[k]),
                        32'(model_word(k)));
        end
    endtask

    // Retires the outstanding CPU request once cpu_rdy is seen
    task automatic finish_cpu();
        int w;
        w = int'(cpu_addr[24:1]);
        cpu_req <= 1'b0;
        cpu_busy = 1'b0;
        if (cpu_in_dl) begin
            check_value("cpu held until download end", 32'd0, 32'(ioctl_download));
            check_image("rom image at cpu grant");
        end
        if (cpu_wr_sel == 2'b00) begin
            check_value($sformatf("cpu read %h", cpu_addr), 32'(expected_word(w)),
                        32'(cpu_dout));
        end else begin
            exp_mem[w] = merge_bytes(expected_word(w), cpu_din, cpu_wr_sel);
        end
    endtask

    task automatic tick();
        @(posedge clk_sys);
        if (cpu_busy && cpu_rdy) begin
            finish_cpu();
        end else if (cpu_rdy) begin
            fail_run("cpu_rdy pulsed with no CPU request outstanding");
        end
    endtask

    // Host byte is held until the DUT takes it
    task automatic send_byte(input m92_dl_pkg::ioctl_index_t idx,
                             input m92_dl_pkg::rom_addr_t addr,
                             input m92_dl_pkg::dip_bank_t data);
        int w;
        w = int'(addr[24:1]);
        tick();
        ioctl_download <= 1'b1;
        ioctl_wr <= 1'b1;
        ioctl_index <= idx;
        ioctl_addr <= addr;
        ioctl_dout <= data;
        tick();
        while (ioctl_wait) begin
            tick();
        end
        ioctl_wr <= 1'b0;
        // Index 0 is ROM, odd address is the upper byte
        if (idx == 8'd0) begin
            exp_mem[w] = merge_bytes(expected_word(w), {data, data},
                                     addr[0] ? 2'b10 : 2'b01);
        end
    endtask

    task automatic end_download();
        tick();
        ioctl_download <= 1'b0;
        // Flush push one cycle later, queued the cycle after
        repeat (3) begin
            tick();
        end
    endtask

    task automatic issue_cpu(input logic [1:0] sel, input m92_dl_pkg::rom_addr_t addr,
                             input m92_dl_pkg::sdr_word_t data);
        while (cpu_busy) begin
            tick();
        end
        tick();
        cpu_addr <= addr;
        cpu_din <= data;
        cpu_wr_sel <= sel;
        cpu_req <= 1'b1;
        cpu_busy = 1'b1;
        // A request raised inside a download completes in the background
        cpu_in_dl = ioctl_download;
        while (cpu_busy && !cpu_in_dl) begin
            tick();
        end
    endtask

    ////////////////////////////// SDRAM model

    always @(posedge clk_sys) begin
        if (reset) begin
            sdr_rdy <= 1'b0;
            busy = 1'b0;
            delay = 0;
        end else if (sdr_rdy) begin
            sdr_rdy <= 1'b0;
        end else if (busy) begin
            if (delay <= 1) begin
                busy = 1'b0;
                sdr_rdy <= 1'b1;
                if (sdr_rnw) begin
                    sdr_dout <= model_word(int'(sdr_addr));
                end else begin
                    sdr_mem[int'(sdr_addr)] = merge_bytes(model_word(int'(sdr_addr)),
                                                          sdr_din, sdr_be);
                end
            end else begin
                delay = delay - 1;
            end
        end else if (sdr_req) begin
            busy = 1'b1;
            delay = 1 + ($unsigned($random(seed)) % 8);
        end
    end

    always @(posedge clk_sys) begin
        if (!reset && ioctl_wait) begin
            wait_seen <= 1'b1;
        end
    end

    // Watchdog
    initial begin
        @(negedge reset);
        repeat (num_records * CYCLES_PER_RECORD) @(posedge clk_sys);
        fail_run("Timeout: the records did not finish in the allowed cycles");
    end

    ////////////////////////////// Stimulus

    initial begin
        logic [31:0] kind;
        logic [31:0] idx;
        logic [31:0] addr;
        logic [31:0] data;
        reset = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_index = '0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        cpu_addr = '0;
        cpu_din = '0;
        cpu_wr_sel = '0;
        cpu_req = 1'b0;
        $readmemh("verification/m92_download_testdata.hex", records);
        while (num_records * 4 < MAX_WORDS && records[num_records * 4] !== 32'hf) begin
            num_records++;
        end
        if (num_records == 0 || num_records * 4 >= MAX_WORDS) begin
            fail_run("The data file is missing, empty or has no end marker");
        end
        repeat (10) @(posedge clk_sys);
        reset <= 1'b0;
        for (int r = 0; r < num_records; r++) begin
            kind = records[4 * r];
            idx = records[4 * r + 1];
            addr = records[4 * r + 2];
            data = records[4 * r + 3];
            case (kind)
                32'h1, 32'h2, 32'h3: send_byte(idx[7:0], addr[24:0], data[7:0]);
                32'h4: end_download();
                32'h5, 32'h6: issue_cpu(idx[1:0], addr[24:0], data[15:0]);
                32'h7: begin
                    tick();
                    check_value("dip switches", 32'(data[23:0]), 32'(dip_sw));
                end
                default: fail_run($sformatf("Record %0d has an unknown kind", r));
            endcase
        end
        while (cpu_busy) begin
            tick();
        end
        check_image("final image");
        check_value("written word count", 32'(exp_mem.num()), 32'(sdr_mem.num()));
        check_value("back-pressure seen", 32'd1, 32'(wait_seen));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* verification/m92_download_testdata.hex */
// kind index addr data: 1 rom byte, 2 dip byte, 3 other index, 4 download end,
// 5 cpu read, 6 cpu write (index holds enables), 7 expected dip, f end of list
7 00 0000000 00ffffff
1 00 0000100 0000003c
1 00 0000101 000000a1
1 00 0000102 00000057
1 00 0000103 000000e2
1 00 0000104 00000019
1 00 0000105 0000006b
1 00 0000106 000000d4
1 00 0000107 00000080
5 00 0000100 00000000
1 00 0000108 0000002f
1 00 0000109 000000c6
1 00 000010a 00000071
1 00 000010b 0000009e
1 00 000010c 00000005
1 00 000010d 000000bb
1 00 000010e 00000048
1 00 000010f 000000f3
4 00 0000000 00000000
6 03 0000200 0000a55a
1 00 00001fe 00000011
1 00 00001ff 00000022
1 00 0000200 00000033
4 00 0000000 00000000
2 fe 0000000 000000fe
2 fe 0000001 000000bf
2 fe 0000002 0000007c
2 fe 0000005 00000012
2 fe 0000008 00000000
3 01 0000001 00000000
4 00 0000000 00000000
7 00 0000000 007cbffe
6 01 0003000 0000beef
5 00 0003000 00000000
5 00 000010e 00000000
5 00 0000200 00000000
f 00 0000000 00000000

/* tb.f */
verilog/m92_dl_pkg.sv
verilog/ioctl_decoder.sv
verilog/rom_word_packer.sv
verilog/rom_write_queue.sv
verilog/sdram_ch3_mux.sv
verilog/m92_download_top.sv
verification/tb_m92_download.sv

/* Makefile */
# Verilator simulation of the M92 download path

VERILATOR ?= verilator
TOP       ?= tb_m92_download
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
